/* bench/imem_model.sv */
`timescale 1ns/1ps
`include "pipe_settings.svh"

module imem_model import pipe_pkg::*; (
   input  logic  clk,
   input  logic  arst_n,
   input  logic  imem_valid,
   output logic  imem_ready,
   input  addr_t imem_address,
   output logic  imem_dp_valid,
   input  logic  imem_dp_ready,
   output word_t imem_dp_read_data
);

   word_t mem [256];
   addr_t pend_q [$];   // Accepted requests in arrival order

   // Unused words hold hlt tagged with their own index
   initial begin
      for (int i = 0; i < 256; i++)
         mem[i] = {`PIPE_OP_HLT, 4'h0, 16'h0, 8'(i)};
   end

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         imem_ready        <= 1'b0;
         imem_dp_valid     <= 1'b0;
         imem_dp_read_data <= '0;
         pend_q.delete();
      end else begin
         if (imem_valid && imem_ready)
            pend_q.push_back(imem_address);
         imem_ready <= ($urandom % 4) != 0;
         if (imem_dp_valid && imem_dp_ready) begin
            void'(pend_q.pop_front());
            imem_dp_valid <= 1'b0;
         end
         // Next answer may follow the last one without a gap
         if ((!imem_dp_valid || imem_dp_ready) && pend_q.size() > 0 &&
             ($urandom % 3) != 0) begin
            imem_dp_valid     <= 1'b1;   // Answers stay in request order
            imem_dp_read_data <= mem[pend_q[0][9:2]];
         end
      end
   end

endmodule

/* bench/tb_pipeline.sv */
`timescale 1ns/1ps
`include "pipe_settings.svh"

module tb_pipeline import pipe_pkg::*; ();

   logic     clk;
   logic     arst_n;
   addr_t    paddr;
   logic     psel;
   logic     penable;
   logic     pwrite;
   word_t    pwdata;
   word_t    prdata;
   logic     imem_valid;
   logic     imem_ready;
   addr_t    imem_address;
   logic     imem_dp_valid;
   logic     imem_dp_ready;
   word_t    imem_dp_read_data;
   logic     retire_valid;
   addr_t    retire_pc;
   reg_num_t retire_reg;
   word_t    retire_data;

   int       mismatches = 0;
   int       failures = 0;
   int       cycles = 0;
   int       limit = 1000;
   int       n_prog = 0;
   int       n_exp = 0;
   logic     run_written = 1'b0;
   logic     check_quiet = 1'b0;
   addr_t    exp_pc [$];
   reg_num_t exp_reg [$];
   word_t    exp_data [$];
   word_t    rd;

   pipeline_top i_dut (.*);

   imem_model i_imem (.*);

   always #50 clk = ~clk;

   function automatic word_t enc(opcode_t op, reg_num_t dst, reg_num_t src, imm_t imm);
      return {op, 1'b0, dst, 1'b0, src, 4'h0, imm};
   endfunction

   task automatic put(addr_t pc, word_t w);
      i_imem.mem[pc[9:2]] = w;
      n_prog++;
   endtask

   task automatic apb_write(addr_t a, word_t d);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= a;
      pwdata  <= d;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(addr_t a, output word_t d);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= a;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      d = prdata;   // Access phase
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // Sequential model of the program held in memory
   task automatic run_model(addr_t start);
      word_t   regs [`PIPE_NREGS];
      addr_t   pc;
      word_t   w;
      word_t   a;
      word_t   b;
      word_t   r;
      opcode_t op;
      pc = start;
      for (int i = 0; i < `PIPE_NREGS; i++)
         regs[i] = '0;
      for (int step = 0; step < 1000; step++) begin
         w  = i_imem.mem[pc[9:2]];
         op = w[31:28];
         a  = regs[w[26:24]];
         b  = regs[w[22:20]];
         if (op == `PIPE_OP_HLT)
            break;
         if (op == `PIPE_OP_JMP) begin
            pc = addr_t'(w[15:0]);
            continue;
         end
         case (op)
            `PIPE_OP_ADD:  r = a + b;
            `PIPE_OP_SUB:  r = a - b;
            `PIPE_OP_AND:  r = a & b;
            `PIPE_OP_OR:   r = a | b;
            `PIPE_OP_XOR:  r = a ^ b;
            `PIPE_OP_MOVI: r = word_t'(w[15:0]);
            default:       r = a + word_t'(w[15:0]);
         endcase
         regs[w[26:24]] = r;
         exp_pc.push_back(pc);
         exp_reg.push_back(w[26:24]);
         exp_data.push_back(r);
         pc = pc + 4;
      end
      n_exp = exp_pc.size();
   endtask

   always @(negedge clk) begin
      if (arst_n && !run_written)
         assert (!imem_valid && !retire_valid) else begin
            failures++;
            $display("imem_valid or retire_valid high before run was set");
         end
      if (check_quiet)
         assert (!imem_valid) else begin
            failures++;
            $display("imem request issued after hlt");
         end
      if (arst_n && retire_valid) begin
         if (exp_pc.size() == 0) begin
            failures++;
            $display("retire at pc %h with no instruction expected", retire_pc);
         end else begin
            assert (retire_pc == exp_pc[0]) else begin
               mismatches++;
               $display("mismatch retire_pc got %h exp %h", retire_pc, exp_pc[0]);
            end
            assert (retire_reg == exp_reg[0]) else begin
               mismatches++;
               $display("mismatch retire_reg got %h exp %h", retire_reg, exp_reg[0]);
            end
            assert (retire_data == exp_data[0]) else begin
               mismatches++;
               $display("mismatch retire_data got %h exp %h", retire_data, exp_data[0]);
            end
            void'(exp_pc.pop_front());
            void'(exp_reg.pop_front());
            void'(exp_data.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout after %0d cycles", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'h20d3_2e2e));
      clk = 1'b0;
      arst_n = 1'b0;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      #1;
      // Setup with ALU ops and bypass chains
      put(32'h40, enc(`PIPE_OP_MOVI, 0, 0, 16'h1234));
      put(32'h44, enc(`PIPE_OP_MOVI, 1, 0, 16'h00ff));
      put(32'h48, enc(`PIPE_OP_MOVI, 2, 0, 16'h0007));
      put(32'h4c, enc(`PIPE_OP_ADD, 0, 1, 16'h0));
      put(32'h50, enc(`PIPE_OP_SUB, 2, 0, 16'h0));
      put(32'h54, enc(`PIPE_OP_AND, 1, 2, 16'h0));
      put(32'h58, enc(`PIPE_OP_MOVI, 3, 0, 16'hf0f0));
      put(32'h5c, enc(`PIPE_OP_XOR, 3, 0, 16'h0));
      put(32'h60, enc(`PIPE_OP_OR, 3, 2, 16'h0));
      put(32'h64, enc(`PIPE_OP_MOVI, 4, 0, 16'h0001));
      put(32'h68, enc(`PIPE_OP_ADDI, 4, 0, 16'h0002));
      put(32'h6c, enc(`PIPE_OP_ADDI, 4, 0, 16'hfff3));
      put(32'h70, enc(`PIPE_OP_JMP, 0, 0, 16'h0080));
      put(32'h74, enc(`PIPE_OP_MOVI, 5, 0, 16'hdead));   // Skipped
      put(32'h78, enc(`PIPE_OP_MOVI, 6, 0, 16'hbeef));
      put(32'h7c, enc(`PIPE_OP_MOVI, 7, 0, 16'h0bad));
      put(32'h80, enc(`PIPE_OP_MOVI, 6, 0, 16'h0100));
      put(32'h84, enc(`PIPE_OP_MOVI, 5, 0, 16'h0005));
      put(32'h88, enc(`PIPE_OP_ADD, 5, 4, 16'h0));
      put(32'h8c, enc(`PIPE_OP_SUB, 6, 5, 16'h0));
      put(32'h90, enc(`PIPE_OP_HLT, 0, 0, 16'h0));
      limit = 40 * n_prog + 200;
      run_model(32'h40);
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      apb_write(`PIPE_APB_START_PC, 32'h40);
      apb_read(`PIPE_APB_START_PC, rd);
      assert (rd == 32'h40) else begin
         mismatches++;
         $display("mismatch start_pc got %h exp %h", rd, 32'h40);
      end
      repeat (5) @(posedge clk);
      apb_write(`PIPE_APB_CONTROL, 32'h1);
      run_written = 1'b1;
      rd = '0;
      while (!rd[0])
         apb_read(`PIPE_APB_STATUS, rd);
      apb_read(`PIPE_APB_CONTROL, rd);
      assert (rd[0] == 1'b0) else begin
         mismatches++;
         $display("mismatch control_run got %h exp %h", rd[0], 1'b0);
      end
      apb_read(`PIPE_APB_RETIRED, rd);
      assert (rd == word_t'(n_exp)) else begin
         mismatches++;
         $display("mismatch retired got %h exp %h", rd, n_exp);
      end
      assert (exp_pc.size() == 0) else begin
         failures++;
         $display("%0d expected instructions never retired", exp_pc.size());
      end
      @(negedge clk);
      while (i_imem.pend_q.size() != 0 || imem_dp_valid)
         @(negedge clk);
      @(posedge clk);
      check_quiet = 1'b1;
      repeat (20) @(posedge clk);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps
`include "pipe_settings.svh"

module execute_unit import pipe_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     d_valid,
   input  opcode_t  d_opcode,
   input  reg_num_t d_dst,
   input  word_t    d_op_a,
   input  word_t    d_op_b,
   input  addr_t    d_pc,
   output logic     ex_result_valid,
   output reg_num_t ex_result_reg,
   output word_t    ex_result,
   output logic     jump_valid,
   output addr_t    jump_target,
   output logic     halt_valid,
   output logic     retire_valid,
   output addr_t    retire_pc,
   output reg_num_t retire_reg,
   output word_t    retire_data
);

   word_t alu_result;
   logic  writes_reg;

   always_comb begin
      writes_reg = 1'b1;
      alu_result = '0;
      case (d_opcode)
         `PIPE_OP_ADD, `PIPE_OP_ADDI: alu_result = d_op_a + d_op_b;
         `PIPE_OP_SUB:                alu_result = d_op_a - d_op_b;
         `PIPE_OP_AND:                alu_result = d_op_a & d_op_b;
         `PIPE_OP_OR:                 alu_result = d_op_a | d_op_b;
         `PIPE_OP_XOR:                alu_result = d_op_a ^ d_op_b;
         `PIPE_OP_MOVI:               alu_result = d_op_b;
         default:                     writes_reg = 1'b0;   // jmp, hlt, spare codes
      endcase
   end

   assign ex_result_valid = d_valid & writes_reg;
   assign ex_result_reg   = d_dst;
   assign ex_result       = alu_result;

   // Resolved here, neither one retires
   assign jump_valid  = d_valid & (d_opcode == `PIPE_OP_JMP);
   assign jump_target = addr_t'(d_op_b);
   assign halt_valid  = d_valid & (d_opcode == `PIPE_OP_HLT);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         retire_valid <= 1'b0;
      else
         retire_valid <= ex_result_valid;
   end

   always_ff @(posedge clk) begin
      if (ex_result_valid) begin
         retire_pc   <= d_pc;
         retire_reg  <= d_dst;
         retire_data <= alu_result;
      end
   end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`include "pipe_settings.svh"

module fetch_unit import pipe_pkg::*; (
   input  logic  clk,
   input  logic  arst_n,
   input  logic  fetch_load,
   input  addr_t fetch_load_address,
   input  logic  fetch_stop,
   output logic  imem_valid,
   input  logic  imem_ready,
   output addr_t imem_address,
   input  logic  imem_dp_valid,
   output logic  imem_dp_ready,
   input  word_t imem_dp_read_data,
   output logic  f_valid,
   input  logic  f_ready,
   output word_t f_instruction,
   output addr_t f_pc
);

   localparam int CNT_W = $clog2(`PIPE_MAX_OUTSTANDING + 1);

   fetch_state_e     state_q;
   fetch_state_e     state_d;
   logic [CNT_W-1:0] cnt_q;
   logic [CNT_W-1:0] cnt_d;
   addr_t            req_pc_q;
   addr_t            resp_pc_q;   // pc of the next kept response
   logic             buf_valid_q;
   word_t            buf_instr_q;
   addr_t            buf_pc_q;
   logic             req_fire;
   logic             resp_fire;
   logic             discard;
   logic             resp_keep;

   assign imem_valid = (state_q == FETCH_RUNNING) & ~fetch_stop & ~fetch_load &
                       (cnt_q < CNT_W'(`PIPE_MAX_OUTSTANDING));
   assign imem_address = req_pc_q;

   // Anything arriving now belongs to the old stream
   assign discard = (state_q == FETCH_DRAINING) | fetch_stop | fetch_load;

   assign imem_dp_ready = (state_q != FETCH_IDLE) & (discard | ~buf_valid_q | f_ready);

   assign req_fire  = imem_valid & imem_ready;
   assign resp_fire = imem_dp_valid & imem_dp_ready;
   assign resp_keep = resp_fire & ~discard;
   assign cnt_d     = cnt_q + CNT_W'(req_fire) - CNT_W'(resp_fire);

   always_comb begin
      state_d = state_q;
      case (state_q)
         FETCH_IDLE: begin
            if (fetch_load && !fetch_stop)
               state_d = FETCH_RUNNING;
         end
         FETCH_RUNNING: begin
            if (cnt_d != '0 && (fetch_stop || fetch_load))
               state_d = FETCH_DRAINING;
            else if (fetch_stop)
               state_d = FETCH_IDLE;
         end
         FETCH_DRAINING: begin
            if (cnt_d == '0)
               state_d = fetch_stop ? FETCH_IDLE : FETCH_RUNNING;
         end
         default: state_d = FETCH_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q     <= FETCH_IDLE;
         cnt_q       <= '0;
         buf_valid_q <= 1'b0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         if (fetch_stop || fetch_load)
            buf_valid_q <= 1'b0;
         else if (resp_keep)
            buf_valid_q <= 1'b1;
         else if (f_ready)
            buf_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_load) begin
         req_pc_q  <= fetch_load_address;
         resp_pc_q <= fetch_load_address;
      end else begin
         if (req_fire)
            req_pc_q <= req_pc_q + addr_t'(4);
         if (resp_keep)
            resp_pc_q <= resp_pc_q + addr_t'(4);
      end
      if (resp_keep) begin
         buf_instr_q <= imem_dp_read_data;
         buf_pc_q    <= resp_pc_q;
      end
   end

   assign f_valid       = buf_valid_q;
   assign f_instruction = buf_instr_q;
   assign f_pc          = buf_pc_q;

endmodule

/* hdl/pipe_pkg.sv */
`include "pipe_settings.svh"

package pipe_pkg;

   // Byte address of an instruction
   typedef logic [`PIPE_ADDR_W-1:0] addr_t;

   typedef logic [`PIPE_DATA_W-1:0] word_t;   // Register value or instruction word

   typedef logic [$clog2(`PIPE_NREGS)-1:0] reg_num_t;

   typedef logic [3:0] opcode_t;

   // Zero-extended for the ALU, absolute target for jmp
   typedef logic [15:0] imm_t;

   typedef enum logic [1:0] {
      FETCH_IDLE,
      FETCH_RUNNING,
      FETCH_DRAINING   // Old responses still in flight
   } fetch_state_e;

endpackage

/* hdl/pipeline_top.sv */
`timescale 1ns/1ps

module pipeline_top import pipe_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  addr_t    paddr,
   input  logic     psel,
   input  logic     penable,
   input  logic     pwrite,
   input  word_t    pwdata,
   output word_t    prdata,
   output logic     imem_valid,
   input  logic     imem_ready,
   output addr_t    imem_address,
   input  logic     imem_dp_valid,
   output logic     imem_dp_ready,
   input  word_t    imem_dp_read_data,
   output logic     retire_valid,
   output addr_t    retire_pc,
   output reg_num_t retire_reg,
   output word_t    retire_data
);

   // Controller
   logic     fetch_load;
   addr_t    fetch_load_address;
   logic     fetch_stop;
   logic     pipe_flush;
   logic     jump_valid;
   addr_t    jump_target;
   logic     halt_valid;

   // Fetch to register access
   logic     f_valid;
   logic     f_ready;
   word_t    f_instruction;
   addr_t    f_pc;

   // Register access to execute
   logic     d_valid;
   opcode_t  d_opcode;
   reg_num_t d_dst;
   word_t    d_op_a;
   word_t    d_op_b;
   addr_t    d_pc;

   // Execute bypass
   logic     ex_result_valid;
   reg_num_t ex_result_reg;
   word_t    ex_result;

   sys_control i_sys_control (.*);

   fetch_unit i_fetch_unit (.*);

   register_access i_register_access (.*);

   execute_unit i_execute_unit (.*);

endmodule

/* hdl/register_access.sv */
`timescale 1ns/1ps
`include "pipe_settings.svh"

module register_access import pipe_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     pipe_flush,
   input  logic     f_valid,
   output logic     f_ready,
   input  word_t    f_instruction,
   input  addr_t    f_pc,
   input  logic     retire_valid,
   input  reg_num_t retire_reg,
   input  word_t    retire_data,
   input  logic     ex_result_valid,
   input  reg_num_t ex_result_reg,
   input  word_t    ex_result,
   output logic     d_valid,
   output opcode_t  d_opcode,
   output reg_num_t d_dst,
   output word_t    d_op_a,
   output word_t    d_op_b,
   output addr_t    d_pc
);

   word_t    regs_q [`PIPE_NREGS];
   opcode_t  f_opcode;
   reg_num_t f_dst;
   reg_num_t f_src;
   imm_t     f_imm;
   word_t    dst_value;
   word_t    src_value;
   logic     use_imm;

   // Youngest producer first, then retire, then the file
   function automatic word_t read_operand(reg_num_t num);
      if (ex_result_valid && ex_result_reg == num)
         return ex_result;
      else if (retire_valid && retire_reg == num)
         return retire_data;
      return regs_q[num];
   endfunction

   assign f_opcode = f_instruction[31:28];
   assign f_dst    = f_instruction[26:24];
   assign f_src    = f_instruction[22:20];
   assign f_imm    = f_instruction[15:0];

   assign f_ready = 1'b1;   // Never stalls

   always_comb begin
      dst_value = read_operand(f_dst);
      src_value = read_operand(f_src);
      case (f_opcode)
         `PIPE_OP_MOVI, `PIPE_OP_ADDI, `PIPE_OP_JMP: use_imm = 1'b1;
         default:                                    use_imm = 1'b0;
      endcase
   end

   // Writeback from the retire register
   always_ff @(posedge clk) begin
      if (retire_valid)
         regs_q[retire_reg] <= retire_data;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         d_valid <= 1'b0;
      else
         d_valid <= f_valid & f_ready & ~pipe_flush;   // Squashed behind jmp or hlt
   end

   always_ff @(posedge clk) begin
      if (f_valid && f_ready) begin
         d_opcode <= f_opcode;
         d_dst    <= f_dst;
         d_op_a   <= dst_value;
         d_op_b   <= use_imm ? word_t'(f_imm) : src_value;
         d_pc     <= f_pc;
      end
   end

endmodule

/* hdl/sys_control.sv */
`timescale 1ns/1ps
`include "pipe_settings.svh"

module sys_control import pipe_pkg::*; (
   input  logic  clk,
   input  logic  arst_n,
   input  addr_t paddr,
   input  logic  psel,
   input  logic  penable,
   input  logic  pwrite,
   input  word_t pwdata,
   output word_t prdata,
   input  logic  jump_valid,
   input  addr_t jump_target,
   input  logic  halt_valid,
   input  logic  retire_valid,
   output logic  fetch_load,
   output addr_t fetch_load_address,
   output logic  fetch_stop,
   output logic  pipe_flush
);

   logic  run_q;
   logic  run_prev_q;
   logic  halted_q;
   addr_t start_pc_q;
   word_t retired_q;
   logic  apb_wr;
   logic  ctrl_wr;
   logic  start_wr;
   logic  run_rise;

   assign apb_wr   = psel & penable & pwrite;   // Access phase, no wait state
   assign ctrl_wr  = apb_wr & (paddr == `PIPE_APB_CONTROL);
   assign start_wr = ctrl_wr & pwdata[0] & ~run_q;
   assign run_rise = run_q & ~run_prev_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run_q      <= 1'b0;
         run_prev_q <= 1'b0;
         halted_q   <= 1'b0;
         start_pc_q <= '0;
         retired_q  <= '0;
      end else begin
         run_prev_q <= run_q;
         if (halt_valid) begin
            run_q    <= 1'b0;
            halted_q <= 1'b1;
         end else if (ctrl_wr) begin
            run_q <= pwdata[0];
            if (start_wr)
               halted_q <= 1'b0;
         end
         if (apb_wr && paddr == `PIPE_APB_START_PC)
            start_pc_q <= addr_t'(pwdata);
         if (start_wr)
            retired_q <= '0;   // New run, new count
         else if (retire_valid)
            retired_q <= retired_q + 1'b1;
      end
   end

   always_comb begin
      prdata = '0;
      case (paddr)
         `PIPE_APB_CONTROL:  prdata[0] = run_q;
         `PIPE_APB_START_PC: prdata    = word_t'(start_pc_q);
         `PIPE_APB_STATUS:   prdata[0] = halted_q;
         `PIPE_APB_RETIRED:  prdata    = retired_q;
         default:            prdata    = '0;
      endcase
   end

   // Jump wins over a start, they never meet in practice
   assign fetch_load         = jump_valid | run_rise;
   assign fetch_load_address = jump_valid ? jump_target : start_pc_q;

   assign fetch_stop = ~run_q | halted_q | halt_valid;
   assign pipe_flush = jump_valid | halt_valid;

endmodule

/* include/pipe_settings.svh */
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

`define PIPE_ADDR_W          32
`define PIPE_DATA_W          32
`define PIPE_NREGS           8   // eax to edi
`define PIPE_MAX_OUTSTANDING 4

// APB register offsets
`define PIPE_APB_CONTROL     32'h0000_0000
`define PIPE_APB_START_PC    32'h0000_0004
`define PIPE_APB_STATUS      32'h0000_0008
`define PIPE_APB_RETIRED     32'h0000_000C

// Opcodes in instruction bits 31:28
`define PIPE_OP_ADD          4'd0
`define PIPE_OP_SUB          4'd1
`define PIPE_OP_AND          4'd2
`define PIPE_OP_OR           4'd3
`define PIPE_OP_XOR          4'd4
`define PIPE_OP_MOVI         4'd5
`define PIPE_OP_ADDI         4'd6
`define PIPE_OP_JMP          4'd7
`define PIPE_OP_HLT          4'd8

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

{ verilator --binary --timing --assert -f vlog.f --top-module tb_pipeline \
     -o sim_tb_pipeline && ./obj_dir/sim_tb_pipeline; } > "$LOG" 2>&1 \
   || echo "*** FAILED ***" >> "$LOG"

cat "$LOG"

grep -qF "*** FAILED ***" "$LOG" && exit 1 || exit 0

/* vlog.f */
+incdir+include
hdl/pipe_pkg.sv
hdl/sys_control.sv
hdl/fetch_unit.sv
hdl/register_access.sv
hdl/execute_unit.sv
hdl/pipeline_top.sv
bench/imem_model.sv
bench/tb_pipeline.sv
